//--- axi_xbar_pkg.sv
`default_nettype none

package axi_xbar_pkg;

	localparam int ADDR_W    = 32;
	localparam int DATA_W    = 32;
	localparam int ID_W      = 4;
	localparam int LEN_W     = 8;
	localparam int N_MASTERS = 2;
	// Two slaves plus the decode-error target
	localparam int N_TARGETS = 3;
	localparam int MIDX_W    = 1;
	localparam int TIDX_W    = 2;
	localparam int SID_W     = ID_W + MIDX_W;

	// Address map with inclusive limits
	localparam logic [ADDR_W-1:0] SLV0_BASE  = 32'h0000_0000;
	localparam logic [ADDR_W-1:0] SLV0_LIMIT = 32'h0FFF_FFFF;
	localparam logic [ADDR_W-1:0] SLV1_BASE  = 32'h1000_0000;
	localparam logic [ADDR_W-1:0] SLV1_LIMIT = 32'h1FFF_FFFF;
	localparam logic [TIDX_W-1:0] ERR_TARGET = 2'd2;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_DECERR = 2'b11;

	// Request controller states
	localparam logic [1:0] REQ_IDLE   = 2'd0;
	localparam logic [1:0] REQ_DECODE = 2'd1;
	localparam logic [1:0] REQ_ISSUE  = 2'd2;

	// Response tracker states
	localparam logic [1:0] RSP_IDLE  = 2'd0;
	localparam logic [1:0] RSP_WAIT  = 2'd1;
	localparam logic [1:0] RSP_BURST = 2'd2;

	// Slave-side ID seen raw or as master index over master ID
	typedef union packed {
		logic [SID_W-1:0] raw;
		struct packed {
			logic [MIDX_W-1:0] midx;
			logic [ID_W-1:0]   id;
		} tag;
	} tagged_id_t;

endpackage

`default_nettype wire

//--- axi_rd_ifs.sv
`default_nettype none

interface ar_chan_if import axi_xbar_pkg::*; ();
	logic              arvalid;
	logic              arready;
	logic [ADDR_W-1:0] araddr;
	tagged_id_t        arid;
	logic [LEN_W-1:0]  arlen;

	modport src (
		output arvalid, araddr, arid, arlen,
		input  arready
	);

	modport dst (
		input  arvalid, araddr, arid, arlen,
		output arready
	);
endinterface

interface r_chan_if import axi_xbar_pkg::*; ();
	logic              rvalid;
	logic              rready;
	logic [DATA_W-1:0] rdata;
	tagged_id_t        rid;
	logic [1:0]        rresp;
	logic              rlast;

	modport src (
		output rvalid, rdata, rid, rresp, rlast,
		input  rready
	);

	modport dst (
		input  rvalid, rdata, rid, rresp, rlast,
		output rready
	);
endinterface

`default_nettype wire

//--- rr_arbiter.sv
`default_nettype none

module rr_arbiter #(
	parameter int N_REQ = 2
) (
	input  wire logic                 clk,
	input  wire logic                 rstn,
	input  wire logic [N_REQ-1:0]     req_i,
	output logic                      gnt_o,
	output logic [$clog2(N_REQ)-1:0]  gnt_id_o
);
	logic                     found;
	logic [$clog2(N_REQ)-1:0] pick;

	// Search upward from the last winner and wrap to the lowest requester
	always_comb begin
		int idx;
		found = 1'b0;
		pick  = gnt_id_o;
		for (int k = 1; k <= N_REQ; k++) begin
			idx = (int'(gnt_id_o) + k) % N_REQ;
			if (!found && req_i[idx]) begin
				found = 1'b1;
				pick  = idx[$clog2(N_REQ)-1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_o    <= 1'b0;
			gnt_id_o <= '0;
		end else if (gnt_o) begin
			// Held until the winner withdraws
			if (!req_i[gnt_id_o]) begin
				gnt_o <= 1'b0;
			end
		end else if (found) begin
			gnt_o    <= 1'b1;
			gnt_id_o <= pick;
		end
	end

endmodule

`default_nettype wire

//--- rd_req_ctrl.sv
`default_nettype none

module rd_req_ctrl import axi_xbar_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rstn,
	input  wire logic              arvalid_i,
	output logic                   arready_o,
	input  wire logic [ADDR_W-1:0] araddr_i,
	input  wire logic [ID_W-1:0]   arid_i,
	input  wire logic [LEN_W-1:0]  arlen_i,
	input  wire logic [MIDX_W-1:0] midx_i,
	output logic [TIDX_W-1:0]      req_tgt_o,
	output logic                   req_o,
	ar_chan_if.src                 ar
);
	logic [1:0]        state;
	logic [ADDR_W-1:0] addr_q;
	logic [LEN_W-1:0]  len_q;
	tagged_id_t        id_q;

	assign arready_o  = rstn && state == REQ_IDLE;
	assign req_o      = state == REQ_ISSUE;
	assign ar.arvalid = state == REQ_ISSUE;
	assign ar.araddr  = addr_q;
	assign ar.arid    = id_q;
	assign ar.arlen   = len_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state     <= REQ_IDLE;
			req_tgt_o <= ERR_TARGET;
		end else begin
			case (state)
				REQ_IDLE: begin
					if (arvalid_i) begin
						state <= REQ_DECODE;
					end
				end
				REQ_DECODE: begin
					// Anything outside both slave windows goes to the error target
					if (addr_q >= SLV0_BASE && addr_q <= SLV0_LIMIT) begin
						req_tgt_o <= TIDX_W'(0);
					end else if (addr_q >= SLV1_BASE && addr_q <= SLV1_LIMIT) begin
						req_tgt_o <= TIDX_W'(1);
					end else begin
						req_tgt_o <= ERR_TARGET;
					end
					state <= REQ_ISSUE;
				end
				REQ_ISSUE: begin
					// Wait for the granted target to take the request
					if (ar.arvalid && ar.arready) begin
						state <= REQ_IDLE;
					end
				end
				default: begin
					state <= REQ_IDLE;
				end
			endcase
		end
	end

	// Request payload tagged with the master index
	always_ff @(posedge clk) begin
		if (arready_o && arvalid_i) begin
			addr_q        <= araddr_i;
			len_q         <= arlen_i;
			id_q.tag.midx <= midx_i;
			id_q.tag.id   <= arid_i;
		end
	end

endmodule

`default_nettype wire

//--- rd_resp_ctrl.sv
`default_nettype none

module rd_resp_ctrl import axi_xbar_pkg::*; (
	input  wire logic         clk,
	input  wire logic         rstn,
	input  wire logic         rvalid_i,
	input  wire logic         rready_i,
	input  wire logic         rlast_i,
	input  wire tagged_id_t   rid_i,
	input  wire logic         gnt_i,
	output logic [MIDX_W-1:0] req_mst_o,
	output logic              req_o,
	output logic              conn_o
);
	logic [1:0] state;

	// Request stays up through the burst so the grant is held
	assign req_o  = state != RSP_IDLE;
	assign conn_o = state == RSP_BURST;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state     <= RSP_IDLE;
			req_mst_o <= '0;
		end else begin
			case (state)
				RSP_IDLE: begin
					// Master comes from the tag bit of the first beat
					if (rvalid_i) begin
						req_mst_o <= rid_i.tag.midx;
						state     <= RSP_WAIT;
					end
				end
				RSP_WAIT: begin
					if (gnt_i) begin
						state <= RSP_BURST;
					end
				end
				RSP_BURST: begin
					if (rvalid_i && rready_i && rlast_i) begin
						state <= RSP_IDLE;
					end
				end
				default: begin
					state <= RSP_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- decerr_slave.sv
`default_nettype none

module decerr_slave import axi_xbar_pkg::*; (
	input wire logic clk,
	input wire logic rstn,
	ar_chan_if.dst   ar,
	r_chan_if.src    r
);
	logic             busy;
	logic [LEN_W-1:0] beat;
	logic [LEN_W-1:0] len_q;
	tagged_id_t       id_q;

	assign ar.arready = !busy;
	assign r.rvalid   = busy;
	assign r.rdata    = '0;
	assign r.rresp    = RESP_DECERR;
	assign r.rid      = id_q;
	assign r.rlast    = busy && beat == len_q;

	// One burst of arlen+1 error beats per accepted request
	always_ff @(posedge clk) begin
		if (!rstn) begin
			busy <= 1'b0;
			beat <= '0;
		end else if (!busy) begin
			if (ar.arvalid) begin
				busy <= 1'b1;
				beat <= '0;
			end
		end else if (r.rready) begin
			if (r.rlast) begin
				busy <= 1'b0;
			end else begin
				beat <= beat + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && ar.arvalid) begin
			id_q  <= ar.arid;
			len_q <= ar.arlen;
		end
	end

endmodule

`default_nettype wire

//--- axi_rd_xbar.sv
`default_nettype none

module axi_rd_xbar import axi_xbar_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rstn,
	input  wire logic              m0_arvalid_i,
	output logic                   m0_arready_o,
	input  wire logic [ADDR_W-1:0] m0_araddr_i,
	input  wire logic [ID_W-1:0]   m0_arid_i,
	input  wire logic [LEN_W-1:0]  m0_arlen_i,
	output logic                   m0_rvalid_o,
	input  wire logic              m0_rready_i,
	output logic [DATA_W-1:0]      m0_rdata_o,
	output logic [ID_W-1:0]        m0_rid_o,
	output logic [1:0]             m0_rresp_o,
	output logic                   m0_rlast_o,
	input  wire logic              m1_arvalid_i,
	output logic                   m1_arready_o,
	input  wire logic [ADDR_W-1:0] m1_araddr_i,
	input  wire logic [ID_W-1:0]   m1_arid_i,
	input  wire logic [LEN_W-1:0]  m1_arlen_i,
	output logic                   m1_rvalid_o,
	input  wire logic              m1_rready_i,
	output logic [DATA_W-1:0]      m1_rdata_o,
	output logic [ID_W-1:0]        m1_rid_o,
	output logic [1:0]             m1_rresp_o,
	output logic                   m1_rlast_o,
	output logic                   s0_arvalid_o,
	input  wire logic              s0_arready_i,
	output logic [ADDR_W-1:0]      s0_araddr_o,
	output logic [SID_W-1:0]       s0_arid_o,
	output logic [LEN_W-1:0]       s0_arlen_o,
	input  wire logic              s0_rvalid_i,
	output logic                   s0_rready_o,
	input  wire logic [DATA_W-1:0] s0_rdata_i,
	input  wire logic [SID_W-1:0]  s0_rid_i,
	input  wire logic [1:0]        s0_rresp_i,
	input  wire logic              s0_rlast_i,
	output logic                   s1_arvalid_o,
	input  wire logic              s1_arready_i,
	output logic [ADDR_W-1:0]      s1_araddr_o,
	output logic [SID_W-1:0]       s1_arid_o,
	output logic [LEN_W-1:0]       s1_arlen_o,
	input  wire logic              s1_rvalid_i,
	output logic                   s1_rready_o,
	input  wire logic [DATA_W-1:0] s1_rdata_i,
	input  wire logic [SID_W-1:0]  s1_rid_i,
	input  wire logic [1:0]        s1_rresp_i,
	input  wire logic              s1_rlast_i
);
	ar_chan_if ar_m [N_MASTERS] ();
	ar_chan_if ar_t [N_TARGETS] ();
	r_chan_if  r_t  [N_TARGETS] ();
	r_chan_if  r_m  [N_MASTERS] ();

	// Flat copies of the interface signals for index-selected muxing
	logic [N_MASTERS-1:0] m_req, m_arvalid, m_rready;
	logic [TIDX_W-1:0]    m_tgt    [N_MASTERS];
	logic [ADDR_W-1:0]    m_araddr [N_MASTERS];
	tagged_id_t           m_arid   [N_MASTERS];
	logic [LEN_W-1:0]     m_arlen  [N_MASTERS];
	logic [N_TARGETS-1:0] t_arready, t_rvalid, t_rready, t_rlast, t_req, t_conn;
	logic [DATA_W-1:0]    t_rdata  [N_TARGETS];
	tagged_id_t           t_rid    [N_TARGETS];
	logic [1:0]           t_rresp  [N_TARGETS];
	logic [MIDX_W-1:0]    t_mst    [N_TARGETS];

	logic [N_MASTERS-1:0] ar_req    [N_TARGETS];
	logic [N_TARGETS-1:0] ar_gnt;
	logic [MIDX_W-1:0]    ar_gnt_id [N_TARGETS];
	logic [N_TARGETS-1:0] r_req     [N_MASTERS];
	logic [N_MASTERS-1:0] r_gnt;
	logic [TIDX_W-1:0]    r_gnt_id  [N_MASTERS];

	rd_req_ctrl u_req_m0 (
		.clk       (clk),
		.rstn      (rstn),
		.arvalid_i (m0_arvalid_i),
		.arready_o (m0_arready_o),
		.araddr_i  (m0_araddr_i),
		.arid_i    (m0_arid_i),
		.arlen_i   (m0_arlen_i),
		.midx_i    (MIDX_W'(0)),
		.req_tgt_o (m_tgt[0]),
		.req_o     (m_req[0]),
		.ar        (ar_m[0])
	);

	rd_req_ctrl u_req_m1 (
		.clk       (clk),
		.rstn      (rstn),
		.arvalid_i (m1_arvalid_i),
		.arready_o (m1_arready_o),
		.araddr_i  (m1_araddr_i),
		.arid_i    (m1_arid_i),
		.arlen_i   (m1_arlen_i),
		.midx_i    (MIDX_W'(1)),
		.req_tgt_o (m_tgt[1]),
		.req_o     (m_req[1]),
		.ar        (ar_m[1])
	);

	for (genvar m = 0; m < N_MASTERS; m++) begin : g_mst
		assign m_arvalid[m] = ar_m[m].arvalid;
		assign m_araddr[m]  = ar_m[m].araddr;
		assign m_arid[m]    = ar_m[m].arid;
		assign m_arlen[m]   = ar_m[m].arlen;
		// Only the target currently granting this master can accept
		assign ar_m[m].arready = t_arready[m_tgt[m]] && ar_gnt[m_tgt[m]]
			&& ar_gnt_id[m_tgt[m]] == MIDX_W'(m);

		for (genvar t = 0; t < N_TARGETS; t++) begin : g_rreq
			assign r_req[m][t] = t_req[t] && t_mst[t] == MIDX_W'(m);
		end

		rr_arbiter #(.N_REQ(N_TARGETS)) u_r_arb (
			.clk      (clk),
			.rstn     (rstn),
			.req_i    (r_req[m]),
			.gnt_o    (r_gnt[m]),
			.gnt_id_o (r_gnt_id[m])
		);

		assign r_m[m].rvalid = r_gnt[m] && t_conn[r_gnt_id[m]] && t_rvalid[r_gnt_id[m]];
		assign r_m[m].rdata  = t_rdata[r_gnt_id[m]];
		assign r_m[m].rid    = t_rid[r_gnt_id[m]];
		assign r_m[m].rresp  = t_rresp[r_gnt_id[m]];
		assign r_m[m].rlast  = t_rlast[r_gnt_id[m]];
		assign m_rready[m]   = r_m[m].rready;
	end

	for (genvar t = 0; t < N_TARGETS; t++) begin : g_tgt
		for (genvar m = 0; m < N_MASTERS; m++) begin : g_arreq
			assign ar_req[t][m] = m_req[m] && m_tgt[m] == TIDX_W'(t);
		end

		rr_arbiter #(.N_REQ(N_MASTERS)) u_ar_arb (
			.clk      (clk),
			.rstn     (rstn),
			.req_i    (ar_req[t]),
			.gnt_o    (ar_gnt[t]),
			.gnt_id_o (ar_gnt_id[t])
		);

		assign ar_t[t].arvalid = ar_gnt[t] && m_arvalid[ar_gnt_id[t]]
			&& m_tgt[ar_gnt_id[t]] == TIDX_W'(t);
		assign ar_t[t].araddr  = m_araddr[ar_gnt_id[t]];
		assign ar_t[t].arid    = m_arid[ar_gnt_id[t]];
		assign ar_t[t].arlen   = m_arlen[ar_gnt_id[t]];
		assign t_arready[t]    = ar_t[t].arready;

		assign t_rvalid[t] = r_t[t].rvalid;
		assign t_rdata[t]  = r_t[t].rdata;
		assign t_rid[t]    = r_t[t].rid;
		assign t_rresp[t]  = r_t[t].rresp;
		assign t_rlast[t]  = r_t[t].rlast;
		// Master back-pressure reaches the target only while joined
		assign t_rready[t]    = t_conn[t] && m_rready[t_mst[t]];
		assign r_t[t].rready  = t_rready[t];

		rd_resp_ctrl u_resp (
			.clk       (clk),
			.rstn      (rstn),
			.rvalid_i  (t_rvalid[t]),
			.rready_i  (t_rready[t]),
			.rlast_i   (t_rlast[t]),
			.rid_i     (t_rid[t]),
			.gnt_i     (r_gnt[t_mst[t]] && r_gnt_id[t_mst[t]] == TIDX_W'(t)),
			.req_mst_o (t_mst[t]),
			.req_o     (t_req[t]),
			.conn_o    (t_conn[t])
		);
	end

	decerr_slave u_decerr (
		.clk  (clk),
		.rstn (rstn),
		.ar   (ar_t[ERR_TARGET]),
		.r    (r_t[ERR_TARGET])
	);

	assign s0_arvalid_o    = ar_t[0].arvalid;
	assign s0_araddr_o     = ar_t[0].araddr;
	assign s0_arid_o       = ar_t[0].arid.raw;
	assign s0_arlen_o      = ar_t[0].arlen;
	assign ar_t[0].arready = s0_arready_i;
	assign r_t[0].rvalid   = s0_rvalid_i;
	assign r_t[0].rdata    = s0_rdata_i;
	assign r_t[0].rid.raw  = s0_rid_i;
	assign r_t[0].rresp    = s0_rresp_i;
	assign r_t[0].rlast    = s0_rlast_i;
	assign s0_rready_o     = r_t[0].rready;

	assign s1_arvalid_o    = ar_t[1].arvalid;
	assign s1_araddr_o     = ar_t[1].araddr;
	assign s1_arid_o       = ar_t[1].arid.raw;
	assign s1_arlen_o      = ar_t[1].arlen;
	assign ar_t[1].arready = s1_arready_i;
	assign r_t[1].rvalid   = s1_rvalid_i;
	assign r_t[1].rdata    = s1_rdata_i;
	assign r_t[1].rid.raw  = s1_rid_i;
	assign r_t[1].rresp    = s1_rresp_i;
	assign r_t[1].rlast    = s1_rlast_i;
	assign s1_rready_o     = r_t[1].rready;

	// Masters see their own ID with the tag bit stripped
	assign m0_rvalid_o    = r_m[0].rvalid;
	assign m0_rdata_o     = r_m[0].rdata;
	assign m0_rid_o       = r_m[0].rid.tag.id;
	assign m0_rresp_o     = r_m[0].rresp;
	assign m0_rlast_o     = r_m[0].rlast;
	assign r_m[0].rready  = m0_rready_i;

	assign m1_rvalid_o    = r_m[1].rvalid;
	assign m1_rdata_o     = r_m[1].rdata;
	assign m1_rid_o       = r_m[1].rid.tag.id;
	assign m1_rresp_o     = r_m[1].rresp;
	assign m1_rlast_o     = r_m[1].rlast;
	assign r_m[1].rready  = m1_rready_i;

endmodule

`default_nettype wire

//--- axi_rd_xbar_asserts.sv
`default_nettype none

module axi_rd_xbar_asserts import axi_xbar_pkg::*; (
	input wire logic              clk,
	input wire logic              rstn,
	input wire logic              m0_arready_o,
	input wire logic              m1_arready_o,
	input wire logic              m0_rvalid_o,
	input wire logic              m1_rvalid_o,
	input wire logic              s0_arvalid_o,
	input wire logic              s0_arready_i,
	input wire logic [ADDR_W-1:0] s0_araddr_o,
	input wire logic [SID_W-1:0]  s0_arid_o,
	input wire logic              s1_arvalid_o,
	input wire logic              s1_arready_i,
	input wire logic [ADDR_W-1:0] s1_araddr_o,
	input wire logic [SID_W-1:0]  s1_arid_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// Reset clears every valid going out of the crossbar
	reset_quiet: assert property (@(posedge clk) !rstn |=>
		!m0_rvalid_o && !m1_rvalid_o && !s0_arvalid_o && !s1_arvalid_o)
		else $error("valid output high after a reset edge");

	s0_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
		s0_arvalid_o && !s0_arready_i |=>
		s0_arvalid_o && $stable(s0_araddr_o) && $stable(s0_arid_o))
		else $error("s0 request changed before arready");

	s1_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
		s1_arvalid_o && !s1_arready_i |=>
		s1_arvalid_o && $stable(s1_araddr_o) && $stable(s1_arid_o))
		else $error("s1 request changed before arready");

	// Tag bit names a master whose request is in flight
	s0_tag_master: assert property (@(posedge clk) disable iff (!rstn)
		s0_arvalid_o |-> (s0_arid_o[SID_W-1] ? !m1_arready_o : !m0_arready_o))
		else $error("s0 arid tag names a master with no request pending");

	s1_tag_master: assert property (@(posedge clk) disable iff (!rstn)
		s1_arvalid_o |-> (s1_arid_o[SID_W-1] ? !m1_arready_o : !m0_arready_o))
		else $error("s1 arid tag names a master with no request pending");

endmodule

bind axi_rd_xbar axi_rd_xbar_asserts u_asserts (
	.clk          (clk),
	.rstn         (rstn),
	.m0_arready_o (m0_arready_o),
	.m1_arready_o (m1_arready_o),
	.m0_rvalid_o  (m0_rvalid_o),
	.m1_rvalid_o  (m1_rvalid_o),
	.s0_arvalid_o (s0_arvalid_o),
	.s0_arready_i (s0_arready_i),
	.s0_araddr_o  (s0_araddr_o),
	.s0_arid_o    (s0_arid_o),
	.s1_arvalid_o (s1_arvalid_o),
	.s1_arready_i (s1_arready_i),
	.s1_araddr_o  (s1_araddr_o),
	.s1_arid_o    (s1_arid_o)
);

`default_nettype wire

//--- tb_axi_rd_xbar.sv
`default_nettype none

module tb_axi_rd_xbar import axi_xbar_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int SEED           = 69460;
	// 200 reads at up to about 60 cycles each, with margin
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int N_RANDOM_READS = 200;
	localparam int MAX_LEN        = 7;
	localparam int N_SLAVES       = 2;

	logic clk;
	logic rstn;

	logic              arvalid [N_MASTERS];
	logic              arready [N_MASTERS];
	logic [ADDR_W-1:0] araddr  [N_MASTERS];
	logic [ID_W-1:0]   arid    [N_MASTERS];
	logic [LEN_W-1:0]  arlen   [N_MASTERS];
	logic              rvalid  [N_MASTERS];
	logic              rready  [N_MASTERS];
	logic [DATA_W-1:0] rdata   [N_MASTERS];
	logic [ID_W-1:0]   rid     [N_MASTERS];
	logic [1:0]        rresp   [N_MASTERS];
	logic              rlast   [N_MASTERS];

	logic              s_arvalid [N_SLAVES];
	logic              s_arready [N_SLAVES];
	logic [ADDR_W-1:0] s_araddr  [N_SLAVES];
	logic [SID_W-1:0]  s_arid    [N_SLAVES];
	logic [LEN_W-1:0]  s_arlen   [N_SLAVES];
	logic              s_rvalid  [N_SLAVES];
	logic              s_rready  [N_SLAVES];
	logic [DATA_W-1:0] s_rdata   [N_SLAVES];
	logic [SID_W-1:0]  s_rid     [N_SLAVES];
	logic [1:0]        s_rresp   [N_SLAVES];
	logic              s_rlast   [N_SLAVES];

	// Outstanding request of each master, as the slaves should see it
	logic [ADDR_W-1:0] req_addr [N_MASTERS];
	logic [ID_W-1:0]   req_id   [N_MASTERS];
	logic [LEN_W-1:0]  req_len  [N_MASTERS];

	int errors          = 0;
	int checks          = 0;
	int tests_passed    = 0;
	int cycles          = 0;
	int slave_ar_cycles = 0;

	axi_rd_xbar dut (
		.clk          (clk),
		.rstn         (rstn),
		.m0_arvalid_i (arvalid[0]),
		.m0_arready_o (arready[0]),
		.m0_araddr_i  (araddr[0]),
		.m0_arid_i    (arid[0]),
		.m0_arlen_i   (arlen[0]),
		.m0_rvalid_o  (rvalid[0]),
		.m0_rready_i  (rready[0]),
		.m0_rdata_o   (rdata[0]),
		.m0_rid_o     (rid[0]),
		.m0_rresp_o   (rresp[0]),
		.m0_rlast_o   (rlast[0]),
		.m1_arvalid_i (arvalid[1]),
		.m1_arready_o (arready[1]),
		.m1_araddr_i  (araddr[1]),
		.m1_arid_i    (arid[1]),
		.m1_arlen_i   (arlen[1]),
		.m1_rvalid_o  (rvalid[1]),
		.m1_rready_i  (rready[1]),
		.m1_rdata_o   (rdata[1]),
		.m1_rid_o     (rid[1]),
		.m1_rresp_o   (rresp[1]),
		.m1_rlast_o   (rlast[1]),
		.s0_arvalid_o (s_arvalid[0]),
		.s0_arready_i (s_arready[0]),
		.s0_araddr_o  (s_araddr[0]),
		.s0_arid_o    (s_arid[0]),
		.s0_arlen_o   (s_arlen[0]),
		.s0_rvalid_i  (s_rvalid[0]),
		.s0_rready_o  (s_rready[0]),
		.s0_rdata_i   (s_rdata[0]),
		.s0_rid_i     (s_rid[0]),
		.s0_rresp_i   (s_rresp[0]),
		.s0_rlast_i   (s_rlast[0]),
		.s1_arvalid_o (s_arvalid[1]),
		.s1_arready_i (s_arready[1]),
		.s1_araddr_o  (s_araddr[1]),
		.s1_arid_o    (s_arid[1]),
		.s1_arlen_o   (s_arlen[1]),
		.s1_rvalid_i  (s_rvalid[1]),
		.s1_rready_o  (s_rready[1]),
		.s1_rdata_i   (s_rdata[1]),
		.s1_rid_i     (s_rid[1]),
		.s1_rresp_i   (s_rresp[1]),
		.s1_rlast_i   (s_rlast[1])
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	always @(posedge clk) begin
		if (s_arvalid[0] || s_arvalid[1]) begin
			slave_ar_cycles++;
		end
	end

	// Address map: slave 1 window, slave 0 window, everything else unmapped
	function automatic int target_of(input logic [ADDR_W-1:0] addr);
		if (addr >= SLV1_BASE && addr <= SLV1_LIMIT) begin
			return 1;
		end else if (addr <= SLV0_LIMIT) begin
			return 0;
		end
		return int'(ERR_TARGET);
	endfunction

	function automatic logic [ADDR_W-1:0] pick_addr(input int tgt);
		logic [ADDR_W-1:0] r;
		logic [3:0]        top;
		r   = $urandom;
		top = (tgt == int'(ERR_TARGET)) ? 4'($urandom_range(15, 2)) : 4'(tgt);
		return {top, r[27:0]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL time=%0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			tests_passed++;
			$display("%s: pass", name);
		end else begin
			$display("%s: %0d errors", name, errors - errs_before);
		end
	endtask

	// One read: AR handshake, then collect beats until rlast
	task automatic master_read(input int m, input logic [ADDR_W-1:0] addr,
			input logic [ID_W-1:0] id, input logic [LEN_W-1:0] len);
		int                beat;
		int                tgt;
		bit                done;
		logic [DATA_W-1:0] exp_data;
		logic [1:0]        exp_resp;
		tgt         = target_of(addr);
		exp_resp    = (tgt == int'(ERR_TARGET)) ? RESP_DECERR : RESP_OKAY;
		req_addr[m] = addr;
		req_id[m]   = id;
		req_len[m]  = len;
		@(negedge clk);
		arvalid[m] = 1'b1;
		araddr[m]  = addr;
		arid[m]    = id;
		arlen[m]   = len;
		@(posedge clk);
		while (!arready[m]) begin
			@(posedge clk);
		end
		beat = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			arvalid[m] = 1'b0;
			rready[m]  = $urandom_range(3) != 0;
			@(posedge clk);
			if (rvalid[m] && rready[m]) begin
				exp_data = (tgt == int'(ERR_TARGET)) ? '0 : addr + DATA_W'(beat);
				check_value($sformatf("m%0d_rdata_o", m), rdata[m], exp_data);
				check_value($sformatf("m%0d_rid_o", m), 32'(rid[m]), 32'(id));
				check_value($sformatf("m%0d_rresp_o", m), 32'(rresp[m]), 32'(exp_resp));
				check_value($sformatf("m%0d_rlast_o", m), 32'(rlast[m]),
					32'(beat == int'(len)));
				beat++;
				done = rlast[m];
			end
		end
		check_value($sformatf("m%0d beat count", m), 32'(beat), 32'(int'(len) + 1));
		@(negedge clk);
		rready[m] = 1'b0;
	endtask

	task automatic random_reads(input int m, input int count);
		int tgt;
		for (int i = 0; i < count; i++) begin
			tgt = $urandom_range(int'(ERR_TARGET));
			master_read(m, pick_addr(tgt), ID_W'($urandom), LEN_W'($urandom_range(MAX_LEN)));
		end
	endtask

	// Slave: one burst at a time, data is address plus beat index
	task automatic slave_serve(input int s);
		logic [ADDR_W-1:0] addr;
		logic [SID_W-1:0]  sid;
		logic [LEN_W-1:0]  len;
		int                mi;
		forever begin
			@(negedge clk);
			s_rvalid[s] = 1'b0;
			s_rlast[s]  = 1'b0;
			repeat ($urandom_range(2)) @(negedge clk);
			s_arready[s] = 1'b1;
			@(posedge clk);
			while (!s_arvalid[s]) begin
				@(posedge clk);
			end
			addr = s_araddr[s];
			sid  = s_arid[s];
			len  = s_arlen[s];
			// tag bit names the master whose request this must be
			mi = int'(sid[SID_W-1]);
			check_value($sformatf("s%0d decoded target", s), 32'(target_of(addr)), 32'(s));
			check_value($sformatf("s%0d_araddr_o", s), addr, req_addr[mi]);
			check_value($sformatf("s%0d_arid_o", s), 32'(sid[ID_W-1:0]), 32'(req_id[mi]));
			check_value($sformatf("s%0d_arlen_o", s), 32'(len), 32'(req_len[mi]));
			for (int b = 0; b <= int'(len); b++) begin
				@(negedge clk);
				s_arready[s] = 1'b0;
				s_rvalid[s]  = 1'b0;
				repeat ($urandom_range(2)) @(negedge clk);
				s_rvalid[s] = 1'b1;
				s_rdata[s]  = addr + DATA_W'(b);
				s_rid[s]    = sid;
				s_rresp[s]  = RESP_OKAY;
				s_rlast[s]  = b == int'(len);
				@(posedge clk);
				while (!s_rready[s]) begin
					@(posedge clk);
				end
			end
		end
	endtask

	initial begin
		int errs;
		int n;
		void'($urandom(SEED));
		rstn = 1'b0;
		for (int i = 0; i < N_MASTERS; i++) begin
			arvalid[i] = 1'b0;
			araddr[i]  = '0;
			arid[i]    = '0;
			arlen[i]   = '0;
			rready[i]  = 1'b0;
		end
		for (int i = 0; i < N_SLAVES; i++) begin
			s_arready[i] = 1'b0;
			s_rvalid[i]  = 1'b0;
			s_rdata[i]   = '0;
			s_rid[i]     = '0;
			s_rresp[i]   = '0;
			s_rlast[i]   = 1'b0;
		end
		repeat (4) @(negedge clk);
		rstn = 1'b1;

		errs = errors;
		@(posedge clk);
		check_value("m0_arready_o", 32'(arready[0]), 1);
		check_value("m1_arready_o", 32'(arready[1]), 1);
		check_value("m0_rvalid_o", 32'(rvalid[0]), 0);
		check_value("m1_rvalid_o", 32'(rvalid[1]), 0);
		check_value("s0_arvalid_o", 32'(s_arvalid[0]), 0);
		check_value("s1_arvalid_o", 32'(s_arvalid[1]), 0);
		report_test("test 1 idle after reset", errs);

		fork
			slave_serve(0);
			slave_serve(1);
		join_none

		errs = errors;
		for (int i = 0; i < 8; i++) begin
			master_read(0, pick_addr(i % 2), ID_W'($urandom), LEN_W'($urandom_range(MAX_LEN)));
		end
		report_test("test 2 m0 reads from both slaves", errs);

		errs = errors;
		n    = slave_ar_cycles;
		for (int i = 0; i < 6; i++) begin
			master_read(i % 2, pick_addr(int'(ERR_TARGET)), ID_W'($urandom),
				LEN_W'($urandom_range(MAX_LEN)));
		end
		check_value("s0_arvalid_o/s1_arvalid_o high cycles", 32'(slave_ar_cycles - n), 0);
		report_test("test 3 unmapped reads", errs);

		errs = errors;
		for (int i = 0; i < 4; i++) begin
			fork
				master_read(0, pick_addr(i % 2), ID_W'($urandom), LEN_W'($urandom_range(MAX_LEN)));
				master_read(1, pick_addr(i % 2), ID_W'($urandom), LEN_W'($urandom_range(MAX_LEN)));
			join
		end
		report_test("test 4 both masters on one slave", errs);

		errs = errors;
		fork
			random_reads(0, N_RANDOM_READS / 2);
			random_reads(1, N_RANDOM_READS / 2);
		join
		// No stray beat may follow the last burst
		@(negedge clk);
		rready[0] = 1'b1;
		rready[1] = 1'b1;
		repeat (20) begin
			@(posedge clk);
			check_value("m0_rvalid_o", 32'(rvalid[0]), 0);
			check_value("m1_rvalid_o", 32'(rvalid[1]), 0);
		end
		report_test("test 5 random mix of reads", errs);

		$display("Checks %0d, errors %0d, tests passed %0d of 5", checks, errors, tests_passed);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
axi_xbar_pkg.sv
axi_rd_ifs.sv
rr_arbiter.sv
rd_req_ctrl.sv
rd_resp_ctrl.sv
decerr_slave.sv
axi_rd_xbar.sv
axi_rd_xbar_asserts.sv
tb_axi_rd_xbar.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the AXI read crossbar testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_axi_rd_xbar \
	-f verilog.f -o tb_sim > build.log 2>&1 &&
./obj_dir/tb_sim 2>&1 | tee sim.log &&
! grep -q "TEST FAILED" sim.log ||
{ echo "Simulation failed, see build.log and sim.log"; exit 1; }

echo "Simulation passed"
